// ==== src/corePkg.sv ====
package corePkg;

    // Data and address width, fixed by the instruction encoding
    localparam int XLEN = 32;
    localparam int NumRegs = 32;
    localparam int A0Index = 10;
    localparam int RegIdxW = $clog2(NumRegs);
    localparam int ImmW = 14;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [RegIdxW-1:0] regIdx_t;

    // Opcode in bits 31..28, all other codes behave as OpNop
    typedef enum logic [3:0] {
        OpNop    = 4'h0,
        OpAlu    = 4'h1,
        OpAluImm = 4'h2,
        OpBeq    = 4'h3,
        OpJal    = 4'h4
    } opcode_e;

    // ALU operation in bits 13..10, unused codes add
    typedef enum logic [3:0] {
        AluAdd  = 4'h0,
        AluSub  = 4'h1,
        AluAnd  = 4'h2,
        AluOr   = 4'h3,
        AluXor  = 4'h4,
        AluSlt  = 4'h5,
        AluSltu = 4'h6,
        AluSll  = 4'h7,
        AluSrl  = 4'h8,
        AluSra  = 4'h9
    } aluOp_e;

    typedef struct packed {
        opcode_e        opcode;
        logic [8:0]     unused;
        regIdx_t        rs2;
        aluOp_e         aluOp;
        regIdx_t        rs1;
        regIdx_t        rd;
    } rForm_t;

    typedef struct packed {
        opcode_e        opcode;
        logic [ImmW-1:0] imm;
        aluOp_e         aluOp;
        regIdx_t        rs1;
        regIdx_t        rd;
    } iForm_t;

    // Same word, register form or immediate form
    typedef union packed {
        rForm_t rForm;
        iForm_t iForm;
    } instr_u;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        opcode_e opcode;
        aluOp_e  aluOp;
        logic    useImm;
        logic    regWrite;
        regIdx_t rs1;
        regIdx_t rs2;
        regIdx_t rd;
        word_t   opA;
        word_t   opB;
        word_t   imm;
    } decoded_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        regIdx_t rd;
        logic    regWrite;
        logic    isLink;
        word_t   aluResult;
        word_t   linkAddr;
    } exResult_t;

    typedef struct packed {
        logic    we;
        regIdx_t addr;
        word_t   data;
    } regWrite_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        regIdx_t rd;
        logic    we;
        word_t   data;
    } retire_t;

endpackage

// ==== src/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import corePkg::*; #(
    parameter int ImemDepth = 256
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         progWe,
    input  logic [$clog2(ImemDepth)-1:0] progAddr,
    input  word_t                        progData,
    input  logic                         redirect,
    input  word_t                        redirectPc,
    output instr_u                       instr,
    output word_t                        pc,
    output logic                         valid
);

    localparam int ImemAddrW = $clog2(ImemDepth);

    word_t imem [ImemDepth];

    word_t fetchPc;
    word_t nextPc;
    logic [ImemAddrW-1:0] fetchIdx;

    // Word index from the pc, upper bits drop so addresses wrap
    assign fetchIdx = fetchPc[ImemAddrW+1:2];

    // Taken branch or jump overrides the sequential step
    assign nextPc = redirect ? redirectPc : fetchPc + word_t'(4);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchPc <= '0;
        end else begin
            fetchPc <= nextPc;
        end
    end

    // Program load port
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // Fetch to decode register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid <= 1'b0;
        end else begin
            valid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        instr <= imem[fetchIdx];
        pc    <= fetchPc;
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile import corePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  regIdx_t   rdAddrA,
    input  regIdx_t   rdAddrB,
    output word_t     rdDataA,
    output word_t     rdDataB,
    input  regWrite_t wr,
    output word_t     a0
);

    word_t regs [NumRegs];

    // Register 0 reads zero and a same-cycle write passes straight through
    function automatic word_t readPort(regIdx_t addr, word_t stored, regWrite_t w);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (w.we && w.addr == addr) begin
            value = w.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rdDataA = readPort(rdAddrA, regs[rdAddrA], wr);
    assign rdDataB = readPort(rdAddrB, regs[rdAddrB], wr);
    assign a0      = regs[A0Index];

endmodule

// ==== src/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit import corePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  instr_u   instr,
    input  word_t    pc,
    input  logic     valid,
    input  logic     flush,
    output regIdx_t  rdAddrA,
    output regIdx_t  rdAddrB,
    input  word_t    rdDataA,
    input  word_t    rdDataB,
    output decoded_t dec
);

    decoded_t decNext;
    word_t    immExt;
    regIdx_t  rs2Idx;

    // Sign-extend the 14-bit immediate field
    assign immExt = {{(XLEN-ImmW){instr.iForm.imm[ImmW-1]}}, instr.iForm.imm};

    // A branch compares rs1 against the register named in rd
    assign rs2Idx  = (instr.rForm.opcode == OpBeq) ? instr.rForm.rd : instr.rForm.rs2;
    assign rdAddrA = instr.rForm.rs1;
    assign rdAddrB = rs2Idx;

    always_comb begin
        decNext          = '0;
        decNext.valid    = valid && !flush;
        decNext.pc       = pc;
        decNext.opcode   = OpNop;
        decNext.aluOp    = AluAdd;
        decNext.useImm   = 1'b0;
        decNext.regWrite = 1'b0;
        decNext.rs1      = instr.rForm.rs1;
        decNext.rs2      = rs2Idx;
        decNext.rd       = instr.rForm.rd;
        decNext.opA      = rdDataA;
        decNext.opB      = rdDataB;
        decNext.imm      = immExt;

        case (instr.rForm.opcode)
            OpAlu: begin
                decNext.opcode   = OpAlu;
                decNext.aluOp    = instr.rForm.aluOp;
                decNext.regWrite = 1'b1;
            end
            OpAluImm: begin
                decNext.opcode   = OpAluImm;
                decNext.aluOp    = instr.iForm.aluOp;
                decNext.useImm   = 1'b1;
                decNext.regWrite = 1'b1;
            end
            OpBeq: begin
                decNext.opcode = OpBeq;
            end
            OpJal: begin
                decNext.opcode   = OpJal;
                decNext.regWrite = 1'b1;
            end
            default: begin
                // Unknown codes retire as no-operation
                decNext.opcode = OpNop;
            end
        endcase
    end

    // Decode to execute register, only valid is cleared on reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dec.valid <= 1'b0;
        end else begin
            dec <= decNext;
        end
    end

endmodule

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import corePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  decoded_t  dec,
    input  regWrite_t fwd,
    output logic      redirect,
    output word_t     redirectPc,
    output exResult_t exr
);

    word_t srcA;
    word_t srcB;
    word_t aluB;
    word_t aluOut;
    logic  isBranch;
    logic  isJump;

    // Writeback bypass when the source matches the pending write
    function automatic word_t forward(regIdx_t idx, word_t regVal, regWrite_t w);
        word_t value;
        if (w.we && idx != '0 && w.addr == idx) begin
            value = w.data;
        end else begin
            value = regVal;
        end
        return value;
    endfunction

    function automatic word_t alu(aluOp_e op, word_t a, word_t b);
        word_t res;
        case (op)
            AluSub:  res = a - b;
            AluAnd:  res = a & b;
            AluOr:   res = a | b;
            AluXor:  res = a ^ b;
            AluSlt:  res = word_t'($signed(a) < $signed(b));
            AluSltu: res = word_t'(a < b);
            AluSll:  res = a << b[4:0];
            AluSrl:  res = a >> b[4:0];
            AluSra:  res = word_t'($signed(a) >>> b[4:0]);
            default: res = a + b;
        endcase
        return res;
    endfunction

    assign srcA   = forward(dec.rs1, dec.opA, fwd);
    assign srcB   = forward(dec.rs2, dec.opB, fwd);
    assign aluB   = dec.useImm ? dec.imm : srcB;
    assign aluOut = alu(dec.aluOp, srcA, aluB);

    assign isBranch = dec.opcode == OpBeq;
    assign isJump   = dec.opcode == OpJal;

    // Branch compares rs1 with rd, offset is in words from this pc
    assign redirect   = dec.valid && (isJump || (isBranch && srcA == srcB));
    assign redirectPc = dec.pc + (dec.imm << 2);

    // Execute to writeback register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exr.valid <= 1'b0;
        end else begin
            exr.valid     <= dec.valid;
            exr.pc        <= dec.pc;
            exr.rd        <= dec.rd;
            exr.regWrite  <= dec.regWrite;
            exr.isLink    <= isJump;
            exr.aluResult <= aluOut;
            exr.linkAddr  <= dec.pc + word_t'(4);
        end
    end

endmodule

// ==== src/resultUnit.sv ====
`timescale 1ns/1ps

module resultUnit import corePkg::*; (
    input  exResult_t exr,
    output regWrite_t wr,
    output retire_t   retire
);

    word_t resultData;
    logic  writeEn;

    // Jumps write the link address, everything else the ALU result
    assign resultData = exr.isLink ? exr.linkAddr : exr.aluResult;

    // Register 0 is never written
    assign writeEn = exr.valid && exr.regWrite && (exr.rd != '0);

    always_comb begin
        wr.we   = writeEn;
        wr.addr = exr.rd;
        wr.data = resultData;
    end

    // Every valid instruction retires, branches too
    always_comb begin
        retire.valid = exr.valid;
        retire.pc    = exr.pc;
        retire.rd    = exr.rd;
        retire.we    = writeEn;
        retire.data  = resultData;
    end

endmodule

// ==== src/coreTop.sv ====
`timescale 1ns/1ps

module coreTop import corePkg::*; #(
    parameter int ImemDepth = 256
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         progWe,
    input  logic [$clog2(ImemDepth)-1:0] progAddr,
    input  word_t                        progData,
    output word_t                        a0,
    output retire_t                      retire
);

    // Fetch to decode
    instr_u fetchInstr;
    word_t  fetchPc;
    logic   fetchValid;

    // Register file read ports
    regIdx_t rdAddrA;
    regIdx_t rdAddrB;
    word_t   rdDataA;
    word_t   rdDataB;

    decoded_t  dec;
    exResult_t exr;
    regWrite_t wr;

    // Redirect also flushes fetch and decode
    logic  redirect;
    word_t redirectPc;

    fetchUnit #(
        .ImemDepth(ImemDepth)
    ) fetchUnit_inst (
        .clk       (clk),
        .rstN      (rstN),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instr     (fetchInstr),
        .pc        (fetchPc),
        .valid     (fetchValid)
    );

    decodeUnit decodeUnit_inst (
        .clk    (clk),
        .rstN   (rstN),
        .instr  (fetchInstr),
        .pc     (fetchPc),
        .valid  (fetchValid),
        .flush  (redirect),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .dec    (dec)
    );

    regFile regFile_inst (
        .clk    (clk),
        .rstN   (rstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wr     (wr),
        .a0     (a0)
    );

    executeUnit executeUnit_inst (
        .clk       (clk),
        .rstN      (rstN),
        .dec       (dec),
        .fwd       (wr),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .exr       (exr)
    );

    resultUnit resultUnit_inst (
        .exr   (exr),
        .wr    (wr),
        .retire(retire)
    );

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Power-on reset for four rising edges
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        rstN = 1'b1;
    end

endmodule

// ==== verif/coreTb.sv ====
`timescale 1ns/1ps

module coreTb import corePkg::*; ();

    localparam int ImemDepth = 256;
    localparam int ImemAddrW = $clog2(ImemDepth);
    localparam int DirectedRetires = 30;
    localparam int RandomRetires = 400;
    // Three cycles per instruction covers a redirect on every one
    localparam int WatchdogCycles = (DirectedRetires + RandomRetires) * 3
                                    + 2 * (ImemDepth + 4) + 4 + 200;

    logic                 clk;
    logic                 porN;
    logic                 rstN;
    logic                 loading;
    logic                 progWe;
    logic [ImemAddrW-1:0] progAddr;
    word_t                progData;
    word_t                a0;
    retire_t              retire;

    word_t   image [ImemDepth];
    word_t   modelRegs [NumRegs];
    word_t   modelPc;
    word_t   expA0;
    word_t   lfsr;
    int      retiredCount;

    assign rstN = porN && !loading;

    clockGen clockGen_inst (
        .clk (clk),
        .rstN(porN)
    );

    coreTop #(
        .ImemDepth(ImemDepth)
    ) coreTop_inst (
        .clk     (clk),
        .rstN    (rstN),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .a0      (a0),
        .retire  (retire)
    );

    task automatic checkValue(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    function automatic logic stepLfsr();
        logic outBit;
        outBit = lfsr[0];
        lfsr = {1'b0, lfsr[XLEN-1:1]};
        if (outBit) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic word_t randBits(int n);
        word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[XLEN-2:0], stepLfsr()};
        end
        return r;
    endfunction

    function automatic word_t rInstr(logic [3:0] op, logic [3:0] fn,
                                     logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {op, 9'b0, rs2, fn, rs1, rd};
    endfunction

    function automatic word_t iInstr(logic [3:0] op, logic [3:0] fn,
                                     logic [4:0] rd, logic [4:0] rs1, logic [13:0] imm);
        return {op, imm, fn, rs1, rd};
    endfunction

    function automatic word_t aluRef(logic [3:0] fn, word_t a, word_t b);
        case (fn)
            AluSub:  return a - b;
            AluAnd:  return a & b;
            AluOr:   return a | b;
            AluXor:  return a ^ b;
            AluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            AluSltu: return (a < b) ? 32'd1 : 32'd0;
            AluSll:  return a << b[4:0];
            AluSrl:  return a >> b[4:0];
            AluSra:  return word_t'($signed(a) >>> b[4:0]);
            default: return a + b;
        endcase
    endfunction

    // Executes the instruction at the model pc and returns what should retire
    function automatic retire_t refStep(output word_t nextA0);
        retire_t exp;
        word_t   w;
        word_t   imm;
        word_t   data;
        word_t   nextPc;
        logic    wrEn;
        w = image[modelPc[ImemAddrW+1:2]];
        imm = {{(XLEN-14){w[27]}}, w[27:14]};
        data = '0;
        wrEn = 1'b0;
        nextPc = modelPc + 32'd4;
        case (w[31:28])
            OpAlu: begin
                data = aluRef(w[13:10], modelRegs[w[9:5]], modelRegs[w[18:14]]);
                wrEn = 1'b1;
            end
            OpAluImm: begin
                data = aluRef(w[13:10], modelRegs[w[9:5]], imm);
                wrEn = 1'b1;
            end
            OpBeq: begin
                if (modelRegs[w[9:5]] == modelRegs[w[4:0]]) begin
                    nextPc = modelPc + (imm << 2);
                end
            end
            OpJal: begin
                data = modelPc + 32'd4;
                wrEn = 1'b1;
                nextPc = modelPc + (imm << 2);
            end
            default: begin
                wrEn = 1'b0;
            end
        endcase
        wrEn = wrEn && (w[4:0] != 5'd0);
        if (wrEn) begin
            modelRegs[w[4:0]] = data;
        end
        exp = '0;
        exp.valid = 1'b1;
        exp.pc = modelPc;
        exp.rd = w[4:0];
        exp.we = wrEn;
        exp.data = data;
        modelPc = nextPc;
        nextA0 = modelRegs[A0Index];
        return exp;
    endfunction

    // Compare on the falling edge where retire has settled
    always @(negedge clk) begin
        retire_t exp;
        word_t   nextA0;
        if (retire.valid === 1'b1) begin
            checkValue("a0", a0, expA0);
            exp = refStep(nextA0);
            checkValue("retire.pc", retire.pc, exp.pc);
            checkValue("retire.rd", word_t'(retire.rd), word_t'(exp.rd));
            checkValue("retire.we", word_t'(retire.we), word_t'(exp.we));
            if (exp.we) begin
                checkValue("retire.data", retire.data, exp.data);
            end
            expA0 = nextA0;
            retiredCount++;
        end
    end

    // Unused words are NOPs carrying their own address
    task automatic buildDirected();
        for (int i = 0; i < ImemDepth; i++) begin
            image[i] = word_t'(i);
        end
        image[0]  = iInstr(OpAluImm, AluAdd, 5'd1, 5'd0, 14'd1234);
        image[1]  = iInstr(OpAluImm, AluAdd, 5'd2, 5'd0, 14'(-7));
        // Dependent chain through a0
        image[2]  = rInstr(OpAlu, AluAdd, 5'd10, 5'd1, 5'd2);
        image[3]  = rInstr(OpAlu, AluSub, 5'd10, 5'd10, 5'd1);
        image[4]  = rInstr(OpAlu, AluAnd, 5'd10, 5'd10, 5'd2);
        image[5]  = rInstr(OpAlu, AluOr, 5'd10, 5'd10, 5'd1);
        image[6]  = rInstr(OpAlu, AluXor, 5'd10, 5'd10, 5'd2);
        image[7]  = rInstr(OpAlu, AluSlt, 5'd10, 5'd2, 5'd10);
        image[8]  = rInstr(OpAlu, AluSltu, 5'd10, 5'd10, 5'd2);
        image[9]  = rInstr(OpAlu, AluSll, 5'd10, 5'd1, 5'd10);
        image[10] = rInstr(OpAlu, AluSrl, 5'd10, 5'd2, 5'd10);
        image[11] = rInstr(OpAlu, AluSra, 5'd10, 5'd2, 5'd10);
        image[12] = iInstr(OpAluImm, AluXor, 5'd3, 5'd1, 14'(-1));
        image[13] = iInstr(OpAluImm, AluAdd, 5'd0, 5'd3, 14'(-100));
        image[14] = iInstr(OpAluImm, AluSra, 5'd4, 5'd3, 14'(-3));
        image[15] = rInstr(OpAlu, AluAdd, 5'd10, 5'd0, 5'd4);
        // Not taken, then taken over two instructions that must not retire
        image[16] = iInstr(OpBeq, AluAdd, 5'd2, 5'd1, 14'd5);
        image[17] = iInstr(OpBeq, AluAdd, 5'd6, 5'd5, 14'd3);
        image[18] = iInstr(OpAluImm, AluAdd, 5'd10, 5'd10, 14'd1);
        image[19] = iInstr(OpAluImm, AluAdd, 5'd10, 5'd10, 14'd2);
        image[20] = iInstr(OpJal, AluAdd, 5'd7, 5'd0, 14'd4);
        image[21] = iInstr(OpAluImm, AluAdd, 5'd10, 5'd10, 14'd3);
        image[22] = iInstr(OpAluImm, AluAdd, 5'd10, 5'd10, 14'd4);
        image[23] = iInstr(OpAluImm, AluAdd, 5'd10, 5'd10, 14'd5);
        image[24] = rInstr(OpAlu, AluAdd, 5'd10, 5'd7, 5'd0);
        image[25] = iInstr(OpJal, AluAdd, 5'd0, 5'd0, 14'd0);
    endtask

    task automatic buildRandom();
        word_t      sel;
        logic [3:0] fn;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        int         target;
        logic [13:0] imm;
        for (int i = 0; i < ImemDepth; i++) begin
            sel = randBits(3);
            fn = 4'(randBits(4));
            rd = 5'(randBits(5));
            rs1 = 5'(randBits(5));
            rs2 = 5'(randBits(5));
            // Short forward hop that wraps to the start of the program
            target = (i + 1 + int'(randBits(3))) % ImemDepth;
            imm = 14'(target - i);
            case (sel)
                0, 1, 2: image[i] = rInstr(OpAlu, fn, rd, rs1, rs2);
                3, 4, 5: image[i] = iInstr(OpAluImm, fn, rd, rs1, 14'(randBits(14)));
                6:       image[i] = iInstr(OpBeq, AluAdd, rd, rs1, imm);
                default: image[i] = iInstr(OpJal, AluAdd, rd, rs1, imm);
            endcase
        end
    endtask

    // Load under reset, then run until enough instructions retired
    task automatic runProgram(int retires);
        @(posedge clk);
        #10;
        loading = 1'b1;
        @(posedge clk);
        #10;
        for (int r = 0; r < NumRegs; r++) begin
            modelRegs[r] = '0;
        end
        modelPc = '0;
        expA0 = '0;
        retiredCount = 0;
        for (int i = 0; i < ImemDepth; i++) begin
            progWe = 1'b1;
            progAddr = ImemAddrW'(i);
            progData = image[i];
            @(posedge clk);
            #10;
            checkValue("retire.valid", word_t'(retire.valid), 32'd0);
            checkValue("a0", a0, 32'd0);
        end
        progWe = 1'b0;
        loading = 1'b0;
        wait (retiredCount >= retires);
    endtask

    initial begin
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        loading = 1'b0;
        lfsr = 32'h41f8bb9d;
        retiredCount = 0;
        expA0 = '0;
        modelPc = '0;
        buildDirected();
        runProgram(DirectedRetires);
        buildRandom();
        runProgram(RandomRetires);
        $display("Done: no errors");
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout: instructions stopped retiring before the tests finished");
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

// ==== Bender.yml ====
package:
  name: coreTop

sources:
  - src/corePkg.sv
  - src/fetchUnit.sv
  - src/regFile.sv
  - src/decodeUnit.sv
  - src/executeUnit.sv
  - src/resultUnit.sv
  - src/coreTop.sv
  - target: simulation
    files:
      - verif/clockGen.sv
      - verif/coreTb.sv

// ==== coreTop.f ====
src/corePkg.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeUnit.sv
src/executeUnit.sv
src/resultUnit.sv
src/coreTop.sv
verif/clockGen.sv
verif/coreTb.sv
